// File: Bender.yml
package:
  name: gat_core

sources:
  - files:
      - src/gat_cfg_pkg.sv
      - src/gat_types_pkg.sv
      - src/gat_weight_sched.sv
      - src/gat_feat_mem.sv
      - src/gat_spmm.sv
      - src/gat_dmvm.sv
      - src/gat_core_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/gat_core_tb.sv

// File: filelist.f
+incdir+sim
src/gat_cfg_pkg.sv
src/gat_types_pkg.sv
src/gat_weight_sched.sv
src/gat_feat_mem.sv
src/gat_spmm.sv
src/gat_dmvm.sv
src/gat_core_top.sv
sim/gat_core_tb.sv

// File: sim/gat_core_tests.svh
// ========================================
// Graph setup, load and result tasks
// Directed tests for the feature core
// ========================================

task automatic clear_graph();
  foreach (w_ref[i, k]) w_ref[i][k] = 0;
  foreach (a_ref[i]) a_ref[i] = 0;
  foreach (row_len[i]) row_len[i] = 0;
  foreach (h_val[i]) begin
    h_val[i] = 0;
    h_col[i] = 0;
  end
  num_nodes = 0;
  h_cnt     = 0;
endtask

// Entries must be added in node order
task automatic add_entry(input int node, input int value, input int col);
  h_val[h_cnt] = value;
  h_col[h_cnt] = col;
  h_cnt++;
  row_len[node]++;
endtask

task automatic apply_reset();
  @(posedge clk);
  rst_n     <= 1'b0;
  wgt_done  <= 1'b0;
  h_done    <= 1'b0;
  info_done <= 1'b0;
  res_ready <= 1'b0;
  repeat (3) @(posedge clk);
  rst_n <= 1'b1;
endtask

// All three memories are written side by side
task automatic load_graph();
  int wv;
  for (int i = 0; i < gat_cfg_pkg::W_DEPTH; i++) begin
    @(posedge clk);
    wv = (i < gat_cfg_pkg::A_BASE) ? w_ref[i / gat_cfg_pkg::FEAT_OUT][i % gat_cfg_pkg::FEAT_OUT]
                                   : a_ref[i - gat_cfg_pkg::A_BASE];
    wgt_wr.en   <= 1'b1;
    wgt_wr.addr <= i[gat_cfg_pkg::W_ADDR_W-1:0];
    wgt_wr.data <= wv[gat_cfg_pkg::DATA_W-1:0];
    h_wr.en     <= (i < gat_cfg_pkg::H_DEPTH);
    h_wr.addr   <= i[gat_cfg_pkg::H_ADDR_W-1:0];
    h_wr.entry.value <= h_val[i % gat_cfg_pkg::H_DEPTH][gat_cfg_pkg::DATA_W-1:0];
    h_wr.entry.col   <= h_col[i % gat_cfg_pkg::H_DEPTH][gat_cfg_pkg::COL_W-1:0];
    info_wr.en   <= (i < gat_cfg_pkg::MAX_NODES);
    info_wr.addr <= i[gat_cfg_pkg::NODE_W-1:0];
    info_wr.info.row_len <= row_len[i % gat_cfg_pkg::MAX_NODES][gat_cfg_pkg::ROW_LEN_W-1:0];
    info_wr.info.last    <= (i == num_nodes - 1);
  end
  @(posedge clk);
  wgt_wr.en  <= 1'b0;
  h_wr.en    <= 1'b0;
  info_wr.en <= 1'b0;
endtask

task automatic check_result(input int idx);
  check_value($sformatf("res_o.node (result %0d)", idx), idx, res.node);
  for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
    check_value($sformatf("res_o.wh[%0d] (node %0d)", k, idx), exp_wh[idx][k], res.wh[k]);
  end
  check_value($sformatf("res_o.e_src (node %0d)", idx), exp_src[idx], res.e_src);
  check_value($sformatf("res_o.e_dst (node %0d)", idx), exp_dst[idx], res.e_dst);
  check_value($sformatf("res_o.last (node %0d)", idx), idx == num_nodes - 1, res.last);
endtask

// Takes all results in order, then checks done and silence
task automatic collect_results(input bit rand_ready);
  int idx;
  bit stalled;
  gat_types_pkg::node_res_t held;
  idx     = 0;
  stalled = 1'b0;
  while (idx < num_nodes) begin
    @(posedge clk);
    res_ready <= rand_ready ? ($urandom_range(1) == 1) : 1'b1;
    @(negedge clk);
    if (stalled) begin
      check_true(res_valid, "res_valid_o dropped while the result was stalled");
      check_true(res === held, "res_o changed while the result was stalled");
    end
    check_true(!done, "done_o high before the last result was accepted");
    stalled = 1'b0;
    if (res_valid && res_ready) begin
      check_result(idx);
      idx++;
    end else if (res_valid) begin
      stalled = 1'b1;
      held    = res;
    end
  end
  // Last transfer happens on this edge
  @(posedge clk);
  res_ready <= 1'b1;
  @(negedge clk);
  check_true(done, "done_o not high after the last result was accepted");
  repeat (20) begin
    @(negedge clk);
    check_true(!res_valid, "extra result after the last node");
    check_true(done, "done_o dropped after completion");
  end
endtask

// ======== Directed tests ================
task automatic test_sched_timing();
  clear_graph();
  num_nodes = 1;
  foreach (w_ref[i, k]) w_ref[i][k] = i - k;
  foreach (a_ref[i]) a_ref[i] = i + 1;
  add_entry(0, 9, 3);
  add_entry(0, -4, 12);
  build_model();
  apply_reset();
  load_graph();
  @(posedge clk);
  wgt_done <= 1'b1;
  // Sweep plus read latency is 73 cycles
  repeat (74) begin
    @(negedge clk);
    check_true(!dut.sched_rdy, "sched_rdy high before the weight sweep finished");
    check_true(!res_valid, "result before all loads were done");
  end
  @(negedge clk);
  check_true(dut.sched_rdy, "sched_rdy not high 73 cycles after wgt_done");
  repeat (20) begin
    @(negedge clk);
    check_true(!res_valid, "result while H and node info were not done");
    check_true(dut.sched_rdy, "sched_rdy dropped after the sweep");
  end
  @(posedge clk);
  h_done    <= 1'b1;
  info_done <= 1'b1;
  collect_results(1'b0);
endtask

task automatic test_identity();
  clear_graph();
  num_nodes = 4;
  for (int i = 0; i < gat_cfg_pkg::FEAT_OUT; i++) begin
    w_ref[i][i] = 1;
  end
  foreach (a_ref[i]) a_ref[i] = 1;
  add_entry(0, 5, 0);
  add_entry(0, -3, 2);
  add_entry(1, 7, 1);
  add_entry(1, 2, 3);
  // Column 9 has a zero weight row
  add_entry(1, -8, 9);
  add_entry(3, -128, 0);
  add_entry(3, 127, 1);
  add_entry(3, 1, 2);
  add_entry(3, 100, 3);
  build_model();
  apply_reset();
  load_graph();
  @(posedge clk);
  wgt_done  <= 1'b1;
  h_done    <= 1'b1;
  info_done <= 1'b1;
  collect_results(1'b0);
endtask

task automatic make_random_graph();
  int len;
  clear_graph();
  num_nodes = gat_cfg_pkg::MAX_NODES;
  foreach (w_ref[i, k]) w_ref[i][k] = int'($urandom_range(255)) - 128;
  foreach (a_ref[i]) a_ref[i] = int'($urandom_range(255)) - 128;
  for (int n = 0; n < num_nodes; n++) begin
    // Node 5 always has an empty row
    len = (n == 5) ? 0 : $urandom_range(4);
    for (int e = 0; e < len; e++) begin
      add_entry(n, int'($urandom_range(255)) - 128, $urandom_range(15));
    end
  end
  build_model();
endtask

task automatic run_graph(input bit rand_ready);
  apply_reset();
  load_graph();
  @(posedge clk);
  wgt_done  <= 1'b1;
  h_done    <= 1'b1;
  info_done <= 1'b1;
  collect_results(rand_ready);
endtask

task automatic test_random_graph();
  make_random_graph();
  run_graph(1'b0);
endtask

// Same graph as the previous test
task automatic test_backpressure();
  run_graph(1'b1);
endtask

// File: sim/gat_core_tb.sv
// ========================================
// Testbench for the feature core
// Clock, reset, DUT, reference model,
// result checks and run timeout
// ========================================

`timescale 1ns/1ps

module gat_core_tb;

  // About 1000 cycles for all tests, doubled
  localparam int TIMEOUT = 2000;

  logic                      clk;
  logic                      rst_n;
  gat_types_pkg::wgt_wr_t    wgt_wr;
  gat_types_pkg::h_wr_t      h_wr;
  gat_types_pkg::info_wr_t   info_wr;
  logic                      wgt_done;
  logic                      h_done;
  logic                      info_done;
  gat_types_pkg::node_res_t  res;
  logic                      res_valid;
  logic                      res_ready;
  logic                      done;

  // ======== Graph and expected results ==
  int w_ref   [gat_cfg_pkg::FEAT_IN][gat_cfg_pkg::FEAT_OUT];
  int a_ref   [gat_cfg_pkg::A_NUM];
  int row_len [gat_cfg_pkg::MAX_NODES];
  int h_val   [gat_cfg_pkg::H_DEPTH];
  int h_col   [gat_cfg_pkg::H_DEPTH];
  int num_nodes;
  int h_cnt;
  logic [gat_cfg_pkg::WH_W-1:0]    exp_wh  [gat_cfg_pkg::MAX_NODES][gat_cfg_pkg::FEAT_OUT];
  // Signed like the result fields, so both widen the same way
  logic signed [gat_cfg_pkg::SCORE_W-1:0] exp_src [gat_cfg_pkg::MAX_NODES];
  logic signed [gat_cfg_pkg::SCORE_W-1:0] exp_dst [gat_cfg_pkg::MAX_NODES];

  int err_cnt;
  int chk_cnt;
  int cycle_cnt;

  gat_core_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_wr_i    (wgt_wr),
    .h_wr_i      (h_wr),
    .info_wr_i   (info_wr),
    .wgt_done_i  (wgt_done),
    .h_done_i    (h_done),
    .info_done_i (info_done),
    .res_o       (res),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .done_o      (done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ======== Check helpers ===============
  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    chk_cnt++;
    assert (exp_v === act_v) else begin
      err_cnt++;
      $display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    chk_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("ERROR: %s", what);
    end
  endtask

  // ======== Reference model =============
  // WH[k] = sum of value * W[col][k], then a dotted with WH
  task automatic build_model();
    int p;
    int whs;
    int src;
    int dst;
    int acc [gat_cfg_pkg::FEAT_OUT];
    p = 0;
    for (int n = 0; n < num_nodes; n++) begin
      for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
        acc[k] = 0;
      end
      for (int e = 0; e < row_len[n]; e++) begin
        for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
          acc[k] += h_val[p] * w_ref[h_col[p]][k];
        end
        p++;
      end
      src = 0;
      dst = 0;
      for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
        exp_wh[n][k] = acc[k][gat_cfg_pkg::WH_W-1:0];
        whs = $signed(exp_wh[n][k]);
        src += a_ref[k] * whs;
        dst += a_ref[gat_cfg_pkg::FEAT_OUT + k] * whs;
      end
      exp_src[n] = src[gat_cfg_pkg::SCORE_W-1:0];
      exp_dst[n] = dst[gat_cfg_pkg::SCORE_W-1:0];
    end
  endtask

  `include "gat_core_tests.svh"

  // ======== Run control =================
  initial begin
    rst_n     = 1'b0;
    wgt_wr    = '0;
    h_wr      = '0;
    info_wr   = '0;
    wgt_done  = 1'b0;
    h_done    = 1'b0;
    info_done = 1'b0;
    res_ready = 1'b0;
    err_cnt   = 0;
    chk_cnt   = 0;
    void'($urandom(32'h4bb5));
    test_sched_timing();
    test_identity();
    test_random_graph();
    test_backpressure();
    $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run did not finish within %0d cycles", TIMEOUT);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: src/gat_cfg_pkg.sv
// ========================================
// Core sizes and data widths
// Weight memory layout: W rows, then a
// ========================================

package gat_cfg_pkg;

  // ======== Data and graph sizes ========
  localparam int DATA_W    = 8;
  localparam int FEAT_IN   = 16;
  localparam int FEAT_OUT  = 4;
  localparam int MAX_NODES = 16;

  localparam int COL_W     = 4;
  // Covers 0 to FEAT_IN
  localparam int ROW_LEN_W = 5;
  localparam int NODE_W    = 4;

  // ======== Sparse feature memory =======
  localparam int H_DEPTH   = 64;
  localparam int H_ADDR_W  = 6;

  // ======== Weight memory ===============
  // W is row-major, one row per input feature
  localparam int W_NUM     = FEAT_IN * FEAT_OUT;
  localparam int A_NUM     = 2 * FEAT_OUT;
  localparam int A_BASE    = W_NUM;
  localparam int W_DEPTH   = A_BASE + A_NUM;
  localparam int W_ADDR_W  = 7;
  localparam int W_COL_W   = $clog2(FEAT_OUT);
  localparam int A_IDX_W   = $clog2(A_NUM);

  // ======== Arithmetic widths ===========
  localparam int WH_W      = 16;
  localparam int PROD_W    = DATA_W + WH_W;
  // Four products summed
  localparam int SCORE_W   = 26;

endpackage

// File: src/gat_core_top.sv
// ========================================
// Feature core top level
// Scheduler, memories, SpMM and DMVM
// ========================================

`timescale 1ns/1ps

module gat_core_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  gat_types_pkg::wgt_wr_t    wgt_wr_i,
  input  gat_types_pkg::h_wr_t      h_wr_i,
  input  gat_types_pkg::info_wr_t   info_wr_i,
  input  logic                      wgt_done_i,
  input  logic                      h_done_i,
  input  logic                      info_done_i,
  output gat_types_pkg::node_res_t  res_o,
  output logic                      res_valid_o,
  input  logic                      res_ready_i,
  output logic                      done_o
);

  logic                                   sched_rdy;
  logic [gat_cfg_pkg::FEAT_IN-1:0][gat_cfg_pkg::FEAT_OUT-1:0]
        [gat_cfg_pkg::DATA_W-1:0]         w_mat;
  logic [gat_cfg_pkg::A_NUM-1:0][gat_cfg_pkg::DATA_W-1:0] a_vec;
  logic [gat_cfg_pkg::H_ADDR_W-1:0]       h_raddr;
  logic [gat_cfg_pkg::NODE_W-1:0]         info_raddr;
  gat_types_pkg::h_entry_t                h_rdata;
  gat_types_pkg::node_info_t              info_rdata;
  gat_types_pkg::node_res_t               wh_res;
  logic                                   wh_valid;
  logic                                   wh_ready;
  logic                                   spmm_start;

  // All three loads must be in place
  assign spmm_start = sched_rdy && h_done_i && info_done_i;

  gat_weight_sched u_weight_sched (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_wr_i    (wgt_wr_i),
    .wgt_done_i  (wgt_done_i),
    .sched_rdy_o (sched_rdy),
    .w_mat_o     (w_mat),
    .a_vec_o     (a_vec)
  );

  gat_feat_mem u_feat_mem (
    .clk          (clk),
    .h_wr_i       (h_wr_i),
    .info_wr_i    (info_wr_i),
    .h_raddr_i    (h_raddr),
    .info_raddr_i (info_raddr),
    .h_rdata_o    (h_rdata),
    .info_rdata_o (info_rdata)
  );

  gat_spmm u_spmm (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (spmm_start),
    .w_mat_i      (w_mat),
    .h_raddr_o    (h_raddr),
    .info_raddr_o (info_raddr),
    .h_rdata_i    (h_rdata),
    .info_rdata_i (info_rdata),
    .out_o        (wh_res),
    .out_valid_o  (wh_valid),
    .out_ready_i  (wh_ready)
  );

  gat_dmvm u_dmvm (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_i        (wh_res),
    .in_valid_i  (wh_valid),
    .in_ready_o  (wh_ready),
    .a_vec_i     (a_vec),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .done_o      (done_o)
  );

endmodule

// File: src/gat_dmvm.sv
// ========================================
// Attention half-scores, two stages
// Products, then e_src and e_dst sums
// ========================================

`timescale 1ns/1ps

module gat_dmvm (
  input  logic                             clk,
  input  logic                             rst_n,
  input  gat_types_pkg::node_res_t         in_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  logic [gat_cfg_pkg::A_NUM-1:0][gat_cfg_pkg::DATA_W-1:0] a_vec_i,
  output gat_types_pkg::node_res_t         res_o,
  output logic                             res_valid_o,
  input  logic                             res_ready_i,
  output logic                             done_o
);

  gat_types_pkg::node_res_t              s1_item_q;
  logic signed [gat_cfg_pkg::PROD_W-1:0] s1_prod_q [gat_cfg_pkg::A_NUM];
  logic                                  s1_vld_q;
  logic                                  s2_vld_q;
  logic                                  s1_free;
  logic                                  s2_free;
  logic signed [gat_cfg_pkg::SCORE_W-1:0] src_sum;
  logic signed [gat_cfg_pkg::SCORE_W-1:0] dst_sum;

  // A stage takes new data when empty or draining
  assign s2_free     = !s2_vld_q || res_ready_i;
  assign s1_free     = !s1_vld_q || s2_free;
  assign in_ready_o  = s1_free;
  assign res_valid_o = s2_vld_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_vld_q <= in_valid_i;
      end
      if (s2_free) begin
        s2_vld_q <= s1_vld_q;
      end
      if (res_valid_o && res_ready_i && res_o.last) begin
        done_o <= 1'b1;
      end
    end
  end

  // ======== Stage 1 products ============
  // First half of a meets WH for e_src, second half for e_dst
  always_ff @(posedge clk) begin
    if (s1_free && in_valid_i) begin
      s1_item_q <= in_i;
      for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
        s1_prod_q[k] <= $signed(a_vec_i[k]) * $signed(in_i.wh[k]);
        s1_prod_q[gat_cfg_pkg::FEAT_OUT + k] <=
          $signed(a_vec_i[gat_cfg_pkg::FEAT_OUT + k]) * $signed(in_i.wh[k]);
      end
    end
  end

  // ======== Stage 2 sums ================
  always_comb begin
    src_sum = '0;
    dst_sum = '0;
    for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
      src_sum = src_sum + s1_prod_q[k];
      dst_sum = dst_sum + s1_prod_q[gat_cfg_pkg::FEAT_OUT + k];
    end
  end

  always_ff @(posedge clk) begin
    if (s2_free && s1_vld_q) begin
      res_o       <= s1_item_q;
      res_o.e_src <= src_sum;
      res_o.e_dst <= dst_sum;
    end
  end

  a_res_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o))
  );

endmodule

// File: src/gat_feat_mem.sv
// ========================================
// H data and node-info memories
// Host write ports, registered core reads
// ========================================

`timescale 1ns/1ps

module gat_feat_mem (
  input  logic                              clk,
  input  gat_types_pkg::h_wr_t              h_wr_i,
  input  gat_types_pkg::info_wr_t           info_wr_i,
  input  logic [gat_cfg_pkg::H_ADDR_W-1:0]  h_raddr_i,
  input  logic [gat_cfg_pkg::NODE_W-1:0]    info_raddr_i,
  output gat_types_pkg::h_entry_t           h_rdata_o,
  output gat_types_pkg::node_info_t         info_rdata_o
);

  gat_types_pkg::h_entry_t   h_mem    [gat_cfg_pkg::H_DEPTH];
  gat_types_pkg::node_info_t info_mem [gat_cfg_pkg::MAX_NODES];

  // ======== H data ======================
  always_ff @(posedge clk) begin
    if (h_wr_i.en) begin
      h_mem[h_wr_i.addr] <= h_wr_i.entry;
    end
    h_rdata_o <= h_mem[h_raddr_i];
  end

  // ======== Node info ===================
  // One word per node, row length and last flag
  always_ff @(posedge clk) begin
    if (info_wr_i.en) begin
      info_mem[info_wr_i.addr] <= info_wr_i.info;
    end
    info_rdata_o <= info_mem[info_raddr_i];
  end

endmodule

// File: src/gat_spmm.sv
// ========================================
// Sparse row times dense W
// Produces one WH vector per node
// ========================================

`timescale 1ns/1ps

module gat_spmm (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start_i,
  input  logic [gat_cfg_pkg::FEAT_IN-1:0][gat_cfg_pkg::FEAT_OUT-1:0]
               [gat_cfg_pkg::DATA_W-1:0]   w_mat_i,
  output logic [gat_cfg_pkg::H_ADDR_W-1:0] h_raddr_o,
  output logic [gat_cfg_pkg::NODE_W-1:0]   info_raddr_o,
  input  gat_types_pkg::h_entry_t          h_rdata_i,
  input  gat_types_pkg::node_info_t        info_rdata_i,
  output gat_types_pkg::node_res_t         out_o,
  output logic                             out_valid_o,
  input  logic                             out_ready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_INFO,
    ST_ENTRIES,
    ST_HOLD
  } state_e;

  state_e                             state_q;
  // One spare bit so an overrun is visible
  logic [gat_cfg_pkg::H_ADDR_W:0]     h_ptr_q;
  logic [gat_cfg_pkg::ROW_LEN_W-1:0]  rem_q;
  logic [gat_cfg_pkg::NODE_W-1:0]     node_q;
  logic                               last_q;
  logic                               finished_q;
  logic                               issue;
  gat_types_pkg::wh_vec_t             acc_q;
  logic signed [gat_cfg_pkg::WH_W-1:0] prod [gat_cfg_pkg::FEAT_OUT];

  assign info_raddr_o = node_q;
  assign h_raddr_o    = h_ptr_q[gat_cfg_pkg::H_ADDR_W-1:0];

  // Entry reads run one cycle ahead of the accumulate
  assign issue = (state_q == ST_INFO && info_rdata_i.row_len != '0) ||
                 (state_q == ST_ENTRIES && rem_q > gat_cfg_pkg::ROW_LEN_W'(1));

  // ======== Control FSM =================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      h_ptr_q    <= '0;
      rem_q      <= '0;
      node_q     <= '0;
      last_q     <= 1'b0;
      finished_q <= 1'b0;
    end else begin
      if (issue) begin
        h_ptr_q <= h_ptr_q + 1'b1;
      end
      case (state_q)
        ST_IDLE: begin
          if (start_i && !finished_q) begin
            state_q <= ST_INFO;
          end
        end
        ST_INFO: begin
          rem_q   <= info_rdata_i.row_len;
          last_q  <= info_rdata_i.last;
          state_q <= (info_rdata_i.row_len == '0) ? ST_HOLD : ST_ENTRIES;
        end
        ST_ENTRIES: begin
          rem_q <= rem_q - 1'b1;
          if (rem_q == gat_cfg_pkg::ROW_LEN_W'(1)) begin
            state_q <= ST_HOLD;
          end
        end
        default: begin
          if (out_ready_i) begin
            state_q <= ST_IDLE;
            if (last_q) begin
              finished_q <= 1'b1;
            end else begin
              node_q <= node_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // ======== Accumulate ==================
  always_comb begin
    for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
      prod[k] = $signed(h_rdata_i.value) * $signed(w_mat_i[h_rdata_i.col][k]);
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_INFO) begin
      acc_q <= '0;
    end else if (state_q == ST_ENTRIES) begin
      for (int k = 0; k < gat_cfg_pkg::FEAT_OUT; k++) begin
        acc_q[k] <= $signed(acc_q[k]) + prod[k];
      end
    end
  end

  // Scores are filled in downstream
  assign out_valid_o = (state_q == ST_HOLD);
  always_comb begin
    out_o      = '0;
    out_o.node = node_q;
    out_o.wh   = acc_q;
    out_o.last = last_q;
  end

  // Packed rows of all nodes must fit the H memory
  a_ptr_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    issue |-> h_ptr_q <= (gat_cfg_pkg::H_ADDR_W + 1)'(gat_cfg_pkg::H_DEPTH - 1)
  );

endmodule

// File: src/gat_types_pkg.sv
// ========================================
// Host write words, memory entries
// and the per-node result record
// ========================================

package gat_types_pkg;

  // ======== Host write ports ============
  typedef struct packed {
    logic                                en;
    logic [gat_cfg_pkg::W_ADDR_W-1:0]    addr;
    logic signed [gat_cfg_pkg::DATA_W-1:0] data;
  } wgt_wr_t;

  // One nonzero of H
  typedef struct packed {
    logic signed [gat_cfg_pkg::DATA_W-1:0] value;
    logic [gat_cfg_pkg::COL_W-1:0]         col;
  } h_entry_t;

  typedef struct packed {
    logic                             en;
    logic [gat_cfg_pkg::H_ADDR_W-1:0] addr;
    h_entry_t                         entry;
  } h_wr_t;

  typedef struct packed {
    logic [gat_cfg_pkg::ROW_LEN_W-1:0] row_len;
    logic                              last;
  } node_info_t;

  typedef struct packed {
    logic                           en;
    logic [gat_cfg_pkg::NODE_W-1:0] addr;
    node_info_t                     info;
  } info_wr_t;

  // ======== Compute results =============
  typedef logic [gat_cfg_pkg::FEAT_OUT-1:0][gat_cfg_pkg::WH_W-1:0] wh_vec_t;

  typedef struct packed {
    logic [gat_cfg_pkg::NODE_W-1:0]         node;
    wh_vec_t                                wh;
    logic signed [gat_cfg_pkg::SCORE_W-1:0] e_src;
    logic signed [gat_cfg_pkg::SCORE_W-1:0] e_dst;
    logic                                   last;
  } node_res_t;

endpackage

// File: src/gat_weight_sched.sv
// ========================================
// Weight memory with host write port
// One sweep after load-done fills W and a
// ========================================

`timescale 1ns/1ps

module gat_weight_sched (
  input  logic                     clk,
  input  logic                     rst_n,
  input  gat_types_pkg::wgt_wr_t   wgt_wr_i,
  input  logic                     wgt_done_i,
  output logic                     sched_rdy_o,
  output logic [gat_cfg_pkg::FEAT_IN-1:0][gat_cfg_pkg::FEAT_OUT-1:0]
               [gat_cfg_pkg::DATA_W-1:0] w_mat_o,
  output logic [gat_cfg_pkg::A_NUM-1:0][gat_cfg_pkg::DATA_W-1:0] a_vec_o
);

  logic [gat_cfg_pkg::DATA_W-1:0]   wmem [gat_cfg_pkg::W_DEPTH];
  logic [gat_cfg_pkg::DATA_W-1:0]   rdata_q;
  logic [gat_cfg_pkg::W_ADDR_W-1:0] rd_cnt_q;
  logic [gat_cfg_pkg::W_ADDR_W-1:0] rd_addr_q;
  logic                             sweep_q;
  logic                             swept_q;
  logic                             rd_vld_q;

  // ======== Memory ======================
  always_ff @(posedge clk) begin
    if (wgt_wr_i.en) begin
      wmem[wgt_wr_i.addr] <= wgt_wr_i.data;
    end
    if (sweep_q) begin
      rdata_q <= wmem[rd_cnt_q];
    end
  end

  // ======== Sweep control ===============
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep_q     <= 1'b0;
      swept_q     <= 1'b0;
      rd_cnt_q    <= '0;
      rd_vld_q    <= 1'b0;
      rd_addr_q   <= '0;
      sched_rdy_o <= 1'b0;
    end else begin
      rd_vld_q  <= sweep_q;
      rd_addr_q <= rd_cnt_q;
      if (!sweep_q && !swept_q && wgt_done_i) begin
        sweep_q  <= 1'b1;
        rd_cnt_q <= '0;
      end else if (sweep_q) begin
        if (rd_cnt_q == gat_cfg_pkg::W_ADDR_W'(gat_cfg_pkg::W_DEPTH - 1)) begin
          sweep_q <= 1'b0;
          swept_q <= 1'b1;
        end else begin
          rd_cnt_q <= rd_cnt_q + 1'b1;
        end
      end
      // Last word lands on this edge
      if (rd_vld_q && rd_addr_q == gat_cfg_pkg::W_ADDR_W'(gat_cfg_pkg::W_DEPTH - 1)) begin
        sched_rdy_o <= 1'b1;
      end
    end
  end

  // Deposit by address
  always_ff @(posedge clk) begin
    if (rd_vld_q) begin
      if (rd_addr_q < gat_cfg_pkg::W_ADDR_W'(gat_cfg_pkg::A_BASE)) begin
        w_mat_o[rd_addr_q[gat_cfg_pkg::W_COL_W +: gat_cfg_pkg::COL_W]]
               [rd_addr_q[gat_cfg_pkg::W_COL_W-1:0]] <= rdata_q;
      end else begin
        a_vec_o[rd_addr_q[gat_cfg_pkg::A_IDX_W-1:0]] <= rdata_q;
      end
    end
  end

  // Host must be finished loading before the sweep reads
  a_no_wr_in_sweep: assert property (
    @(posedge clk) disable iff (!rst_n) sweep_q |-> !wgt_wr_i.en
  );

endmodule
